//--- glay_mem_router.f
+incdir+common
common/glay_data_pkg.sv
common/glay_ctrl_pkg.sv
source/mux_bus_one_hot.sv
source/demux_bus_one_hot.sv
router/glay_router_control.sv
source/glay_mem_router.sv
test/glay_mem_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f glay_mem_router.f \
  --top-module glay_mem_router_tb \
  -o glay_mem_router_sim

status=0
output=$(./obj_dir/glay_mem_router_sim 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  echo "Simulation PASSED"
  exit 0
fi
echo "Simulation FAILED (exit status $status)"
exit 1

//--- test/glay_mem_router_tb.sv
// ------------------------------
// Testbench for the memory-read router
// Engine and memory models, checks at the falling edge
// Memory answers in order after 0 to 6 cycles
// Responses are withheld in periodic windows to fill credit
// Response data is the request address XOR a fixed pattern
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "glay_router_defs.svh"

module glay_mem_router_tb;

  localparam int NUM_ENG = `GLAY_NUM_ENGINES;
  localparam int IDX_SHIFT = `GLAY_ADDR_WIDTH - $clog2(`GLAY_NUM_ENGINES);
  localparam int MAX_OUT = `GLAY_MAX_OUTSTANDING;
  localparam int NUM_REQ = 400;
  localparam realtime CLK_PERIOD = 100.0;
  localparam realtime DRIVE_DELAY = 1.0;
  localparam glay_data_pkg::vertex_addr_t RESP_PATTERN = 32'h5A3C_96E1;

  logic                        ap_clk = 1'b0;
  logic                        areset;
  glay_data_pkg::engine_mask_t engine_req;
  glay_data_pkg::vertex_addr_t engine_addr [NUM_ENG-1:0];
  logic                        mem_resp_valid;
  glay_data_pkg::vertex_data_t mem_resp_data;
  glay_data_pkg::engine_mask_t engine_grant;
  logic                        mem_req_valid;
  glay_data_pkg::vertex_addr_t mem_req_addr;
  glay_data_pkg::engine_mask_t engine_resp_valid;
  glay_data_pkg::vertex_data_t engine_resp_data;

  // Stimulus state
  integer seed = 84136;
  int     cycle = 0;
  int     issued = 0;
  int     gap [NUM_ENG];
  int     seq [NUM_ENG];
  // Memory model, pending reads and their due cycles
  glay_data_pkg::vertex_addr_t mem_addr_q [$];
  int                          mem_due_q [$];
  // Scoreboard, requests in memory order and responses in flight
  glay_data_pkg::vertex_addr_t order_q [$];
  glay_data_pkg::vertex_addr_t resp_exp_q [$];
  // One-cycle history taken at the falling edge
  glay_data_pkg::engine_mask_t grant_q = '0;
  glay_data_pkg::engine_mask_t req_prev = '0;
  glay_data_pkg::engine_mask_t grant_prev = '0;
  glay_data_pkg::vertex_addr_t grant_addr_prev = '0;
  logic                        mem_resp_d1 = 1'b0;
  logic                        mem_resp_d2 = 1'b0;
  int                          last_idx = NUM_ENG - 1;
  bit                          first_grant_seen = 1'b0;
  int                          max_out = 0;
  bit                          done = 1'b0;

  glay_mem_router uut (
    .ap_clk            (ap_clk),
    .areset            (areset),
    .engine_req        (engine_req),
    .engine_addr       (engine_addr),
    .mem_resp_valid    (mem_resp_valid),
    .mem_resp_data     (mem_resp_data),
    .engine_grant      (engine_grant),
    .mem_req_valid     (mem_req_valid),
    .mem_req_addr      (mem_req_addr),
    .engine_resp_valid (engine_resp_valid),
    .engine_resp_data  (engine_resp_data)
  );

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  // Engine index sits in the top address bits
  function automatic glay_data_pkg::vertex_addr_t make_addr(input int eng, input int s);
    return (glay_data_pkg::vertex_addr_t'(eng) << IDX_SHIFT) | glay_data_pkg::vertex_addr_t'(s);
  endfunction

  function automatic int onehot_index(input glay_data_pkg::engine_mask_t mask);
    for (int i = 0; i < NUM_ENG; i++) begin
      if (mask[i]) return i;
    end
    return -1;
  endfunction

  // First candidate at or after start, wrapping
  function automatic int pick_round_robin(input glay_data_pkg::engine_mask_t cand,
                                          input int start);
    int idx;
    for (int i = 0; i < NUM_ENG; i++) begin
      idx = (start + i) % NUM_ENG;
      if (cand[idx]) return idx;
    end
    return -1;
  endfunction

  // ------------------------------
  // Engine and memory models
  // ------------------------------

  // Granted engine drops or renews, others count down their gap
  task automatic drive_engines();
    for (int i = 0; i < NUM_ENG; i++) begin
      if (engine_req[i] && grant_q[i]) begin
        engine_req[i] = 1'b0;
        seq[i]++;
        gap[i] = $unsigned($random(seed)) % 4;
      end else if (!engine_req[i] && gap[i] > 0) begin
        gap[i]--;
      end
      if (!engine_req[i] && gap[i] == 0 && issued < NUM_REQ) begin
        engine_req[i]  = 1'b1;
        engine_addr[i] = make_addr(i, seq[i]);
        issued++;
      end
    end
  endtask

  // In-order answers, held back in a window of every 64 cycles
  task automatic drive_memory();
    bit hold;
    hold = (cycle % 64) >= 40;
    if (mem_req_valid) begin
      mem_addr_q.push_back(mem_req_addr);
      mem_due_q.push_back(cycle + 1 + ($unsigned($random(seed)) % 7));
    end
    mem_resp_valid = 1'b0;
    if (!hold && mem_addr_q.size() > 0 && mem_due_q[0] <= cycle) begin
      mem_resp_valid = 1'b1;
      mem_resp_data  = glay_data_pkg::vertex_data_t'(mem_addr_q.pop_front() ^ RESP_PATTERN);
      void'(mem_due_q.pop_front());
    end
  endtask

  initial begin
    areset         = 1'b1;
    engine_req     = '0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    for (int i = 0; i < NUM_ENG; i++) begin
      engine_addr[i] = '0;
      gap[i]         = 0;
      seq[i]         = 0;
    end
    repeat (2) @(posedge ap_clk);
    #(DRIVE_DELAY);
    areset = 1'b0;
    forever begin
      drive_memory();
      drive_engines();
      @(posedge ap_clk);
      cycle++;
      #(DRIVE_DELAY);
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Shape, source level, no back-to-back, round-robin order
  task automatic check_grants();
    int idx;
    assert ($onehot0(engine_grant))
      else stop_on_error($sformatf("MISMATCH at %0t: grant %b not one-hot", $time, engine_grant));
    if (engine_grant != '0) begin
      idx = onehot_index(engine_grant);
      assert ((engine_grant & ~req_prev) == '0 && (engine_grant & ~engine_req) == '0)
        else stop_on_error($sformatf("MISMATCH at %0t: grant to idle engine %0d", $time, idx));
      assert ((engine_grant & grant_prev) == '0)
        else stop_on_error($sformatf("MISMATCH at %0t: engine %0d granted twice", $time, idx));
      // First grant after reset, all engines requesting
      assert (first_grant_seen || idx == 0)
        else stop_on_error($sformatf("MISMATCH at %0t: first grant to %0d", $time, idx));
      assert (idx == pick_round_robin(req_prev & ~grant_prev, last_idx + 1))
        else stop_on_error($sformatf("MISMATCH at %0t: grant %0d out of rotation", $time, idx));
      first_grant_seen = 1'b1;
      last_idx         = idx;
    end
  endtask

  // Request strobe one cycle after grant, credit bound
  task automatic check_requests();
    assert (mem_req_valid == (grant_prev != '0))
      else stop_on_error($sformatf("MISMATCH at %0t: mem_req_valid %b", $time, mem_req_valid));
    if (mem_req_valid) begin
      assert (mem_req_addr == grant_addr_prev)
        else stop_on_error($sformatf("MISMATCH at %0t: mem_req_addr %h, expected %h",
                                     $time, mem_req_addr, grant_addr_prev));
      order_q.push_back(grant_addr_prev);
    end
    if (mem_resp_valid) begin
      assert (order_q.size() > 0)
        else stop_on_error("Memory model answered a read that was never issued");
      resp_exp_q.push_back(order_q.pop_front());
    end
    assert (order_q.size() <= MAX_OUT)
      else stop_on_error($sformatf("MISMATCH at %0t: %0d reads outstanding", $time,
                                   order_q.size()));
    if (order_q.size() > max_out) max_out = order_q.size();
  endtask

  // Two-cycle response latency, owner lane and data
  task automatic check_responses();
    glay_data_pkg::vertex_addr_t a;
    assert ($onehot0(engine_resp_valid))
      else stop_on_error($sformatf("MISMATCH at %0t: resp valid %b", $time, engine_resp_valid));
    assert ((engine_resp_valid != '0) == mem_resp_d2)
      else stop_on_error($sformatf("MISMATCH at %0t: resp valid %b, latency off",
                                   $time, engine_resp_valid));
    if (engine_resp_valid != '0) begin
      a = resp_exp_q.pop_front();
      assert (engine_resp_valid == (glay_data_pkg::engine_mask_t'(1) << (a >> IDX_SHIFT)))
        else stop_on_error($sformatf("MISMATCH at %0t: addr %h routed to %b", $time, a,
                                     engine_resp_valid));
      assert (engine_resp_data == glay_data_pkg::vertex_data_t'(a ^ RESP_PATTERN))
        else stop_on_error($sformatf("MISMATCH at %0t: resp data %h for addr %h", $time,
                                     engine_resp_data, a));
    end
  endtask

  always @(negedge ap_clk) begin
    if (areset) begin
      assert (engine_grant == '0 && !mem_req_valid && engine_resp_valid == '0)
        else stop_on_error($sformatf("MISMATCH at %0t: outputs active in reset", $time));
      last_idx         = NUM_ENG - 1;
      first_grant_seen = 1'b0;
    end else begin
      check_grants();
      check_requests();
      check_responses();
      done = issued >= NUM_REQ && engine_req == '0 && engine_grant == '0 && !mem_req_valid
             && order_q.size() == 0 && resp_exp_q.size() == 0;
    end
    if (engine_grant != '0) grant_addr_prev = engine_addr[onehot_index(engine_grant)];
    mem_resp_d2 = mem_resp_d1;
    mem_resp_d1 = mem_resp_valid;
    req_prev    = engine_req;
    grant_prev  = engine_grant;
    grant_q     = engine_grant;
  end

  initial begin
    wait (done);
    assert (max_out == MAX_OUT) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_on_error("Outstanding reads never reached the credit limit");
    end
  end

  // Watchdog, 20 cycles per request
  initial begin
    #(NUM_REQ * 20 * CLK_PERIOD);
    stop_on_error("Timeout: the router stopped making progress before all reads completed");
  end

endmodule : glay_mem_router_tb

`default_nettype wire

//--- source/glay_mem_router.sv
// ------------------------------
// Memory-read router top level
// Request reaches memory one cycle after the grant
// Response reaches the engine two cycles after memory
// In-order memory only, no write path
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "glay_router_defs.svh"

module glay_mem_router (
  input  logic                        ap_clk,
  input  logic                        areset,
  input  glay_data_pkg::engine_mask_t engine_req,
  input  glay_data_pkg::vertex_addr_t engine_addr [`GLAY_NUM_ENGINES-1:0],
  input  logic                        mem_resp_valid,
  input  glay_data_pkg::vertex_data_t mem_resp_data,
  output glay_data_pkg::engine_mask_t engine_grant,
  output logic                        mem_req_valid,
  output glay_data_pkg::vertex_addr_t mem_req_addr,
  output glay_data_pkg::engine_mask_t engine_resp_valid,
  output glay_data_pkg::vertex_data_t engine_resp_data
);

  // Owner of the response in flight
  glay_data_pkg::engine_mask_t resp_sel;
  // Response strobe fanned out to every lane
  glay_data_pkg::engine_mask_t resp_valid_lanes;
  // Demux lanes, all carry the same word
  glay_data_pkg::vertex_data_t resp_data_lanes [`GLAY_NUM_ENGINES-1:0];

  // ------------------------------
  // Control
  // ------------------------------

  glay_router_control u_control (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .engine_req     (engine_req),
    .mem_resp_valid (mem_resp_valid),
    .engine_grant   (engine_grant),
    .resp_sel       (resp_sel)
  );

  // ------------------------------
  // Request path
  // ------------------------------

  // Grant doubles as the mux select
  mux_bus_one_hot u_req_mux (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .sel_in         (engine_grant),
    .data_in        (engine_addr),
    .data_out       (mem_req_addr),
    .data_out_valid (mem_req_valid)
  );

  // ------------------------------
  // Response path
  // ------------------------------

  assign resp_valid_lanes = {`GLAY_NUM_ENGINES{mem_resp_valid}};

  demux_bus_one_hot u_resp_demux (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .sel_in         (resp_sel),
    .data_in_valid  (resp_valid_lanes),
    .data_in        (mem_resp_data),
    .data_out       (resp_data_lanes),
    .data_out_valid (engine_resp_valid)
  );

  // Shared data bus, any lane will do
  assign engine_resp_data = resp_data_lanes[0];

endmodule : glay_mem_router

`default_nettype wire

//--- router/glay_router_control.sv
// ------------------------------
// Round-robin read arbiter with credit limit
// Grant is registered, one cycle after the sampled request
// Engine granted last cycle is masked out
// Memory responses must come back in request order
// Owner FIFO never pops when empty, memory answers only requests
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "glay_router_defs.svh"

module glay_router_control (
  input  logic                        ap_clk,
  input  logic                        areset,
  input  glay_data_pkg::engine_mask_t engine_req,
  input  logic                        mem_resp_valid,
  output glay_data_pkg::engine_mask_t engine_grant,
  output glay_data_pkg::engine_mask_t resp_sel
);

  localparam int NUM_ENG = `GLAY_NUM_ENGINES;
  localparam int PTR_W   = $clog2(NUM_ENG);
  localparam int FIFO_AW = $clog2(`GLAY_MAX_OUTSTANDING);
  localparam glay_ctrl_pkg::credit_count_t CREDIT_MAX = `GLAY_MAX_OUTSTANDING;

  // Arbiter FSM
  glay_ctrl_pkg::arb_state_t    arb_state;
  glay_ctrl_pkg::arb_state_t    arb_state_next;
  // Requests minus the stale one
  glay_data_pkg::engine_mask_t  req_masked;
  glay_data_pkg::engine_mask_t  grant_pick;
  // Round-robin start position
  logic [PTR_W-1:0]             rr_ptr;
  logic [PTR_W-1:0]             rr_ptr_next;
  // Credit tracking
  glay_ctrl_pkg::credit_count_t credit_count;
  glay_ctrl_pkg::credit_count_t credit_count_next;
  // Owner FIFO of granted masks
  glay_data_pkg::engine_mask_t  owner_fifo [`GLAY_MAX_OUTSTANDING-1:0];
  logic [FIFO_AW-1:0]           wr_ptr;
  logic [FIFO_AW-1:0]           rd_ptr;
  logic                         push;
  logic                         pop;

  // ------------------------------
  // Round-robin pick
  // ------------------------------

  // Grant currently out means that level is stale
  assign req_masked = engine_req & ~engine_grant;

  // Search starts at rr_ptr, first hit wins
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_pick  = '0;
    rr_ptr_next = rr_ptr;
    found       = 1'b0;
    for (int i = 0; i < NUM_ENG; i++) begin
      idx = (int'(rr_ptr) + i) % NUM_ENG;
      if (!found && req_masked[idx]) begin
        found           = 1'b1;
        grant_pick[idx] = 1'b1;
        // Next search begins after the winner
        rr_ptr_next     = PTR_W'((idx + 1) % NUM_ENG);
      end
    end
  end

  // ------------------------------
  // Credit counter
  // ------------------------------

  // Push while a grant is out, pop on each response
  assign push = (arb_state == glay_ctrl_pkg::ARB_GRANT);
  assign pop  = mem_resp_valid;

  // Net change of push and pop
  always_comb begin
    case ({push, pop})
      2'b10:   credit_count_next = credit_count + 1'b1;
      2'b01:   credit_count_next = credit_count - 1'b1;
      default: credit_count_next = credit_count;
    endcase
  end

  // ------------------------------
  // Arbiter FSM
  // ------------------------------

  // Full store blocks the next grant
  always_comb begin
    if (credit_count_next == CREDIT_MAX) begin
      arb_state_next = glay_ctrl_pkg::ARB_STALL;
    end else if (|req_masked) begin
      arb_state_next = glay_ctrl_pkg::ARB_GRANT;
    end else begin
      arb_state_next = glay_ctrl_pkg::ARB_IDLE;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      arb_state    <= glay_ctrl_pkg::ARB_IDLE;
      engine_grant <= '0;
      rr_ptr       <= '0;
      credit_count <= '0;
    end else begin
      arb_state    <= arb_state_next;
      credit_count <= credit_count_next;
      if (arb_state_next == glay_ctrl_pkg::ARB_GRANT) begin
        engine_grant <= grant_pick;
        rr_ptr       <= rr_ptr_next;
      end else begin
        engine_grant <= '0;
      end
    end
  end

  // ------------------------------
  // Owner FIFO
  // ------------------------------

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage holds the mask granted this cycle
  always_ff @(posedge ap_clk) begin
    if (push) begin
      owner_fifo[wr_ptr] <= engine_grant;
    end
  end

  // Head presented in the response cycle
  assign resp_sel = pop ? owner_fifo[rd_ptr] : '0;

endmodule : glay_router_control

`default_nettype wire

//--- source/demux_bus_one_hot.sv
// ------------------------------
// One-hot response demultiplexer
// Fixed two-cycle latency, input then output register
// Data copied to every lane, valid on the selected one
// Data registers carry no reset
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "glay_router_defs.svh"

module demux_bus_one_hot (
  input  logic                        ap_clk,
  input  logic                        areset,
  input  glay_data_pkg::engine_mask_t sel_in,
  input  glay_data_pkg::engine_mask_t data_in_valid,
  input  glay_data_pkg::vertex_data_t data_in,
  output glay_data_pkg::vertex_data_t data_out [`GLAY_NUM_ENGINES-1:0],
  output glay_data_pkg::engine_mask_t data_out_valid
);

  // Input stage
  glay_data_pkg::vertex_data_t data_in_int;
  glay_data_pkg::engine_mask_t sel_in_int;
  glay_data_pkg::engine_mask_t data_in_valid_int;
  // Per-lane valid before the output stage
  glay_data_pkg::engine_mask_t lane_valid;

  // ------------------------------
  // Input register
  // ------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      sel_in_int        <= '0;
      data_in_valid_int <= '0;
    end else begin
      sel_in_int        <= sel_in;
      data_in_valid_int <= data_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    data_in_int <= data_in;
  end

  // ------------------------------
  // Lane steering
  // ------------------------------

  // Select bit gated by its own valid
  assign lane_valid = sel_in_int & data_in_valid_int;

  // Output register
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      data_out_valid <= '0;
    end else begin
      data_out_valid <= lane_valid;
    end
  end

  // Broadcast data to all lanes
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < `GLAY_NUM_ENGINES; i++) begin
      data_out[i] <= data_in_int;
    end
  end

endmodule : demux_bus_one_hot

`default_nettype wire

//--- source/mux_bus_one_hot.sv
// ------------------------------
// One-hot request multiplexer
// sel_in must be zero or one-hot
// Output appears one cycle after the select
// Address is captured while the engine still holds it
// ------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "glay_router_defs.svh"

module mux_bus_one_hot (
  input  logic                       ap_clk,
  input  logic                       areset,
  input  glay_data_pkg::engine_mask_t sel_in,
  input  glay_data_pkg::vertex_addr_t data_in [`GLAY_NUM_ENGINES-1:0],
  output glay_data_pkg::vertex_addr_t data_out,
  output logic                       data_out_valid
);

  // Masked OR of all lanes
  glay_data_pkg::vertex_addr_t data_or;
  // Any lane selected
  logic                        sel_any;

  // ------------------------------
  // Select logic
  // ------------------------------

  // Only the selected lane survives the mask
  always_comb begin
    data_or = '0;
    for (int i = 0; i < `GLAY_NUM_ENGINES; i++) begin
      if (sel_in[i]) begin
        data_or = data_or | data_in[i];
      end
    end
  end

  // Valid when any select bit set
  assign sel_any = |sel_in;

  // ------------------------------
  // Output register
  // ------------------------------

  // Strobe is control state
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      data_out_valid <= 1'b0;
    end else begin
      data_out_valid <= sel_any;
    end
  end

  // Address register, payload only
  always_ff @(posedge ap_clk) begin
    data_out <= data_or;
  end

endmodule : mux_bus_one_hot

`default_nettype wire

//--- common/glay_ctrl_pkg.sv
// ------------------------------
// Control types for the router arbiter
// Counter width covers the full credit limit
// ------------------------------

`default_nettype none

`include "glay_router_defs.svh"

package glay_ctrl_pkg;

  // Arbiter states
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_GRANT = 2'd1,
    ARB_STALL = 2'd2
  } arb_state_t;

  // Outstanding reads, 0 up to GLAY_MAX_OUTSTANDING inclusive
  typedef logic [$clog2(`GLAY_MAX_OUTSTANDING+1)-1:0] credit_count_t;

endpackage : glay_ctrl_pkg

`default_nettype wire

//--- common/glay_data_pkg.sv
// ------------------------------
// Datapath vector types for the router
// Widths come from the router defines header
// ------------------------------

`default_nettype none

`include "glay_router_defs.svh"

package glay_data_pkg;

  // ------------------------------
  // Payload types
  // ------------------------------

  // One vertex address on the request path
  typedef logic [`GLAY_ADDR_WIDTH-1:0] vertex_addr_t;

  // One vertex data word on the response path
  typedef logic [`GLAY_DATA_WIDTH-1:0] vertex_data_t;

  // One bit per engine
  // Used for request levels, grants and response selects
  typedef logic [`GLAY_NUM_ENGINES-1:0] engine_mask_t;

endpackage : glay_data_pkg

`default_nettype wire

//--- common/glay_router_defs.svh
// ------------------------------
// Size settings for the memory-read router
// GLAY_MAX_OUTSTANDING must be a power of two and at least 2
// GLAY_NUM_ENGINES must be at least 2
// ------------------------------

`ifndef GLAY_ROUTER_DEFS_SVH
`define GLAY_ROUTER_DEFS_SVH

// Vertex engines sharing the read port
`define GLAY_NUM_ENGINES 4

// Vertex address width in bits
`define GLAY_ADDR_WIDTH 32

// Vertex data width in bits
`define GLAY_DATA_WIDTH 32

// Owner FIFO depth, also the credit limit
`define GLAY_MAX_OUTSTANDING 4

`endif
